// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - files:
      - rtl/i2cPkg.sv
      - rtl/i2cCommandLatch.sv
      - rtl/i2cBitTimer.sv
      - rtl/i2cByteSequencer.sv
      - rtl/i2cReadCapture.sv
      - rtl/i2cMaster.sv
  - target: test
    files:
      - bench/i2cSlaveModel.sv
      - bench/i2cMasterAssertions.sv
      - bench/i2cMasterTb.sv

// ==== bench/i2cMasterAssertions.sv ====
`timescale 1ns/1ps

module i2cMasterAssertions
(
	input logic clk,
	input logic reset,
	input logic sda,
	input logic scl,
	input i2cPkg::busPhase_t phase,
	input logic ready,
	input logic sended,
	input logic received
);

	int failCount = 0;	// failed properties so far

	// sda may only move under a high scl for start, restart and stop
	sdaStable: assert property (@(posedge clk) disable iff (!reset)
		($changed(sda) && scl && $past(scl)) |->
		(phase inside {i2cPkg::phaseIdle, i2cPkg::phaseStart, i2cPkg::phaseRestartRelease,
			i2cPkg::phaseRestartStart, i2cPkg::phaseStop}))
		else
		begin
			failCount++;
			$error("sda moved while scl was high");
		end

	sendedPulse: assert property (@(posedge clk) disable iff (!reset) sended |=> !sended)
		else
		begin
			failCount++;
			$error("sended high for two cycles");
		end

	receivedPulse: assert property (@(posedge clk) disable iff (!reset) received |=> !received)
		else
		begin
			failCount++;
			$error("received high for two cycles");
		end

	readyBusFree: assert property (@(posedge clk) disable iff (!reset) ready |-> scl)
		else
		begin
			failCount++;
			$error("ready high with scl held low");
		end

endmodule

// ==== bench/i2cMasterTb.sv ====
`timescale 1ns/1ps

module i2cMasterTb;

	localparam int quarter = 4;	// clk cycles per quarter scl period
	localparam int timeoutCycles = 5 * 6 * 36 * quarter + 2000;	// five transfers plus margin

	logic clk;
	logic reset;
	logic start;
	logic send;
	logic receive;
	byte dataSend;
	logic ready;
	logic sended;
	logic received;
	byte dataReceive;
	wire sda;
	wire scl;

	byte expRegs[4];	// what the slave registers should hold
	int cycles;
	logic sclWindow;	// scl intervals are measured while set
	logic sclLast;
	logic runCounted;
	int runLen;
	int runsChecked;

	pullup (sda);
	pullup (scl);

	i2cMaster #(.quarterCycles(quarter)) dut_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.send(send),
		.receive(receive),
		.dataSend(dataSend),
		.ready(ready),
		.sended(sended),
		.received(received),
		.dataReceive(dataReceive),
		.sda(sda),
		.scl(scl)
	);

	i2cSlaveModel #(.address(7'h50)) slaveModel
	(
		.clk(clk),
		.sda(sda),
		.scl(scl)
	);

	bind i2cMaster i2cMasterAssertions assertions_i
	(
		.clk(clk),
		.reset(reset),
		.sda(sda),
		.scl(scl),
		.phase(phase),
		.ready(ready),
		.sended(sended),
		.received(received)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic tick();	// inputs change just after the edge
		@(posedge clk);
		#1;
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > timeoutCycles)
		begin
			$display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	// a failed bus property ends the run
	always @(posedge clk)
	begin
		if (dut_i.assertions_i.failCount != 0)
		begin
			$display("a bus assertion failed");
			$display("Result: FAILED");
			$fatal(1, "assertion");
		end
	end

	// each scl level run that starts inside the window must be 2Q long
	always @(posedge clk)
	begin
		if (scl !== sclLast)
		begin
			if (runCounted)
			begin
				check("scl interval", runLen, 2 * quarter);
				runsChecked++;
			end
			runLen = 1;
			runCounted = sclWindow;
			sclLast = scl;
		end
		else
			runLen++;
	end

	task automatic writeTransfer(input logic [6:0] addr, input byte payload[$],
		input logic measure, output int sendedCount, output int receivedCount);
		int idx;
		logic busy;
		idx = 0;
		busy = 1'b0;
		sendedCount = 0;
		receivedCount = 0;
		dataSend = {addr, 1'b0};
		start = 1'b1;
		tick();
		start = 1'b0;
		while (!(busy && ready))
		begin
			tick();
			send = 1'b0;	// one-cycle strobe
			if (!ready)
				busy = 1'b1;
			if (received)
				receivedCount++;
			if (sended)
			begin
				sendedCount++;
				sclWindow = measure && (sendedCount == 1 || sendedCount == 2);
				if (idx < payload.size())
				begin
					dataSend = payload[idx];
					idx++;
					send = 1'b1;
				end
			end
		end
		sclWindow = 1'b0;
	endtask

	// restart set: write address first, then a repeated start to the read address
	task automatic readTransfer(input logic [6:0] addr, input int count, input logic restart,
		output byte got[$]);
		int sendedCount;
		logic busy;
		sendedCount = 0;
		busy = 1'b0;
		got = {};
		dataSend = {addr, !restart};
		start = 1'b1;
		tick();
		start = 1'b0;
		while (!(busy && ready))
		begin
			tick();
			start = 1'b0;
			receive = 1'b0;
			if (!ready)
				busy = 1'b1;
			if (sended)
			begin
				sendedCount++;
				if (restart && sendedCount == 1)
				begin
					start = 1'b1;
					dataSend = {addr, 1'b1};
				end
				else
					receive = 1'b1;	// first read byte
			end
			if (received)
			begin
				got.push_back(dataReceive);
				if (got.size() < count)
					receive = 1'b1;	// master acks and reads on
			end
		end
	endtask

	task automatic testReset();
		check("ready", ready, 1);
		check("sended", sended, 0);
		check("received", received, 0);
		check("sda", sda, 1);
		check("scl", scl, 1);
	endtask

	task automatic testWrite();
		byte payload[$];
		int s;
		int r;
		payload.push_back(byte'($urandom));
		payload.push_back(byte'($urandom));
		writeTransfer(7'h50, payload, 1'b1, s, r);
		check("sended count", s, 3);
		check("received count", r, 0);
		expRegs[0] = payload[0];
		expRegs[1] = payload[1];
		check("slave reg0", slaveModel.regs[0], expRegs[0]);
		check("slave reg1", slaveModel.regs[1], expRegs[1]);
		check("scl runs measured", runsChecked, 36);	// address ack, byte ack, two bytes of bits
	endtask

	task automatic testRead();
		byte got[$];
		int ackBase;
		ackBase = slaveModel.masterAcks.size();
		readTransfer(7'h50, 3, 1'b0, got);
		check("read byte count", got.size(), 3);
		for (int i = 0; i < 3; i++)
			check("dataReceive", got[i], expRegs[i]);
		check("master ack 0", slaveModel.masterAcks[ackBase], 1);
		check("master ack 1", slaveModel.masterAcks[ackBase + 1], 1);
		check("master ack 2", slaveModel.masterAcks[ackBase + 2], 0);	// nack on last
	endtask

	task automatic testAddrNack();
		byte payload[$];
		int s;
		int r;
		int stops;
		stops = slaveModel.stopCount;
		payload.push_back(byte'($urandom));
		writeTransfer(7'h51, payload, 1'b0, s, r);
		check("sended count", s, 1);
		check("received count", r, 0);
		check("stop count", slaveModel.stopCount - stops, 1);
		for (int i = 0; i < 4; i++)
			check("slave reg", slaveModel.regs[i], expRegs[i]);
	endtask

	task automatic testRestart();
		byte got[$];
		int starts;
		int stops;
		starts = slaveModel.startCount;
		stops = slaveModel.stopCount;
		readTransfer(7'h50, 1, 1'b1, got);
		check("start count", slaveModel.startCount - starts, 2);
		check("stop count", slaveModel.stopCount - stops, 1);
		check("slave rw", slaveModel.lastRw, 1);
		check("read byte count", got.size(), 1);
		check("dataReceive", got[0], expRegs[0]);
	endtask

	initial
	begin
		reset = 1'b0;
		start = 1'b0;
		send = 1'b0;
		receive = 1'b0;
		dataSend = 8'h00;
		cycles = 0;
		sclWindow = 1'b0;
		sclLast = 1'b1;
		runCounted = 1'b0;
		runLen = 0;
		runsChecked = 0;
		void'($urandom(89));
		for (int i = 0; i < 4; i++)
			expRegs[i] = byte'(8'h5A ^ (i * 8'h37));	// slave power-up contents
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b1;
		tick();
		testReset();
		testWrite();
		testRead();
		testAddrNack();
		testRestart();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== bench/i2cSlaveModel.sv ====
`timescale 1ns/1ps

module i2cSlaveModel
#(
	parameter logic [6:0] address = 7'h50	// 7-bit bus address this slave answers
)
(
	input logic clk,
	inout wire sda,
	inout wire scl
);

	localparam int sIdle = 0;
	localparam int sAddr = 1;	// shifting in the address byte
	localparam int sWrite = 2;	// shifting in a data byte
	localparam int sRead = 3;	// shifting out a register
	localparam int sAckOut = 4;	// slave holds sda low for its ack
	localparam int sAckIn = 5;	// master ack or nack on a read byte

	byte regs[4];	// small register file
	int state;
	int afterAck;	// state to enter once the slave ack ends
	int bitCnt;
	int startCount;	// start and restart conditions seen
	int stopCount;
	logic [7:0] shiftIn;
	logic [7:0] shiftOut;
	logic [1:0] ptr;	// register pointer, back to zero on each start
	logic pullLow;
	logic sdaLast;
	logic sclLast;
	logic lastRw;	// rw bit of the last matching address
	logic masterAcks[$];	// one entry per read byte, 1 means ack

	assign sda = pullLow ? 1'b0 : 1'bz;

	initial
	begin
		for (int i = 0; i < 4; i++)
			regs[i] = byte'(8'h5A ^ (i * 8'h37));	// fill from the whole register address
		state = sIdle;
		afterAck = sIdle;
		bitCnt = 0;
		startCount = 0;
		stopCount = 0;
		ptr = '0;
		pullLow = 1'b0;
		sdaLast = 1'b1;
		sclLast = 1'b1;
		lastRw = 1'b0;
	end

	// bus lines oversampled on clk so simultaneous edges need no ordering
	always @(posedge clk)
	begin
		if (sclLast && scl && sdaLast && !sda)
		begin
			startCount++;	// start or repeated start
			state = sAddr;
			bitCnt = 0;
			ptr = '0;
			pullLow = 1'b0;
		end
		else if (sclLast && scl && !sdaLast && sda)
		begin
			stopCount++;
			state = sIdle;
			pullLow = 1'b0;
		end
		else if (!sclLast && scl)
		begin
			case (state)
				sAddr, sWrite:
				begin
					shiftIn = {shiftIn[6:0], sda};
					bitCnt++;
				end
				sRead: bitCnt++;
				sAckIn: masterAcks.push_back(!sda);
				default: ;
			endcase
		end
		else if (sclLast && !scl)
		begin
			case (state)
				sAddr, sWrite:
					if (bitCnt == 8)
					begin
						if (state == sAddr && shiftIn[7:1] != address)
							state = sIdle;	// not us, stay off the bus
						else
						begin
							if (state == sAddr)
							begin
								lastRw = shiftIn[0];
								afterAck = shiftIn[0] ? sRead : sWrite;
							end
							else
							begin
								regs[ptr] = shiftIn;
								ptr++;
								afterAck = sWrite;
							end
							pullLow = 1'b1;	// ack
							state = sAckOut;
						end
					end
				sAckOut:
				begin
					pullLow = 1'b0;
					state = afterAck;
					bitCnt = 0;
					if (state == sRead)
					begin
						shiftOut = regs[ptr];
						pullLow = !shiftOut[7];
					end
				end
				sRead:
					if (bitCnt == 8)
					begin
						pullLow = 1'b0;	// let the master ack
						ptr++;
						state = sAckIn;
					end
					else
						pullLow = !shiftOut[7 - bitCnt];
				sAckIn:
					if (masterAcks[$])
					begin
						state = sRead;
						bitCnt = 0;
						shiftOut = regs[ptr];
						pullLow = !shiftOut[7];
					end
					else
						state = sIdle;	// nack ends the read
				default: ;
			endcase
		end
		sdaLast = sda;
		sclLast = scl;
	end

endmodule

// ==== build.f ====
rtl/i2cPkg.sv
rtl/i2cCommandLatch.sv
rtl/i2cBitTimer.sv
rtl/i2cByteSequencer.sv
rtl/i2cReadCapture.sv
rtl/i2cMaster.sv
bench/i2cSlaveModel.sv
bench/i2cMasterAssertions.sv
bench/i2cMasterTb.sv

// ==== rtl/i2cBitTimer.sv ====
`timescale 1ns/1ps

module i2cBitTimer
#(
	parameter int quarterCycles = 62	// clk cycles per quarter scl period
)
(
	input logic clk,
	input logic reset,
	input i2cPkg::busPhase_t phase,
	output logic phaseDone,
	output logic sclRelease
);

	localparam int countBits = $clog2(4 * quarterCycles);	// longest phase is stop, 4Q

	typedef logic [countBits-1:0] count_t;

	localparam count_t quarter = count_t'(quarterCycles);
	localparam count_t half = count_t'(2 * quarterCycles);
	localparam count_t startLast = count_t'(3 * quarterCycles - 1);
	localparam count_t stopLast = count_t'(4 * quarterCycles - 1);

	count_t count;	// cycles spent in the current phase
	count_t lastCount;	// final count of the current phase

	always_comb
	begin
		case (phase)
			i2cPkg::phaseStart: lastCount = startLast;
			i2cPkg::phaseStop: lastCount = stopLast;
			default: lastCount = half - 1'b1;	// every bit and restart phase is 2Q
		endcase
	end

	assign phaseDone = (phase != i2cPkg::phaseIdle) && (count == lastCount);

	always_ff @(posedge clk)
	begin
		if (!reset)
			count <= '0;
		else if ((phase == i2cPkg::phaseIdle) || phaseDone)
			count <= '0;	// next phase starts from zero
		else
			count <= count + 1'b1;
	end

	// scl shape per phase, low means the pin is pulled down
	always_comb
	begin
		case (phase)
			i2cPkg::phaseIdle,
			i2cPkg::phaseBitHigh,
			i2cPkg::phaseAckHigh,
			i2cPkg::phaseReadHigh,
			i2cPkg::phaseMasterAckHigh: sclRelease = 1'b1;
			i2cPkg::phaseStart: sclRelease = (count < half);	// high 2Q then low Q
			i2cPkg::phaseRestartRelease: sclRelease = (count >= quarter);	// low then up
			i2cPkg::phaseRestartStart: sclRelease = (count < quarter);	// up then low
			i2cPkg::phaseStop: sclRelease = (count >= half);	// low 2Q then up
			default: sclRelease = 1'b0;	// all low bit phases
		endcase
	end

endmodule

// ==== rtl/i2cByteSequencer.sv ====
`timescale 1ns/1ps

module i2cByteSequencer
(
	input logic clk,
	input logic reset,
	input i2cPkg::pendingReq_t pending,
	input byte dataSend,
	input logic ackSeen,
	input logic phaseDone,
	output i2cPkg::busPhase_t phase,
	output i2cPkg::pendingReq_t consume,
	output i2cPkg::sampleCmd_t sample,
	output logic sdaRelease,
	output logic ready,
	output logic sended
);

	i2cPkg::busPhase_t nextPhase;
	i2cPkg::bitIndex_t bitIdx;	// bit on the bus, counts down
	logic readMode;	// rw bit of the last address byte
	logic addrByte;	// the byte in flight is an address
	logic moreRead;	// host wants another read byte, so master acks
	logic lastBit;
	logic byteSent;	// last write bit just finished

	assign lastBit = (bitIdx == '0);
	assign byteSent = (phase == i2cPkg::phaseBitHigh) && phaseDone && lastBit;
	assign ready = (phase == i2cPkg::phaseIdle);

	assign sample = '{
		sampleAck: (phase == i2cPkg::phaseAckHigh) && phaseDone,
		sampleData: (phase == i2cPkg::phaseReadHigh) && phaseDone,
		clearAck: byteSent
	};

	always_comb
	begin
		nextPhase = phase;
		consume = '0;
		case (phase)
			i2cPkg::phaseIdle:
			begin
				consume.send = 1'b1;	// data requests only count inside a transaction
				consume.receive = 1'b1;
				if (pending.start)
				begin
					nextPhase = i2cPkg::phaseStart;
					consume.start = 1'b1;
				end
			end
			i2cPkg::phaseStart,
			i2cPkg::phaseRestartStart:
				if (phaseDone)
					nextPhase = i2cPkg::phaseBitLow;	// address byte follows
			i2cPkg::phaseRestartRelease:
				if (phaseDone)
					nextPhase = i2cPkg::phaseRestartStart;
			i2cPkg::phaseBitLow:
				if (phaseDone)
					nextPhase = i2cPkg::phaseBitHigh;
			i2cPkg::phaseBitHigh:
				if (phaseDone)
					nextPhase = lastBit ? i2cPkg::phaseAckLow : i2cPkg::phaseBitLow;
			i2cPkg::phaseAckLow:
				if (phaseDone)
					nextPhase = i2cPkg::phaseAckHigh;
			i2cPkg::phaseAckHigh:
			begin
				if (phaseDone)
				begin
					if (!ackSeen)
						nextPhase = i2cPkg::phaseStop;	// slave nack ends it
					else if (addrByte && pending.start)
					begin
						nextPhase = i2cPkg::phaseRestartRelease;
						consume.start = 1'b1;
					end
					else if (readMode && pending.receive)
					begin
						nextPhase = i2cPkg::phaseReadLow;
						consume.receive = 1'b1;
					end
					else if (!readMode && pending.send)
					begin
						nextPhase = i2cPkg::phaseBitLow;
						consume.send = 1'b1;
					end
					else
						nextPhase = i2cPkg::phaseStop;	// nothing more asked for
				end
			end
			i2cPkg::phaseReadLow:
				if (phaseDone)
					nextPhase = i2cPkg::phaseReadHigh;
			i2cPkg::phaseReadHigh:
				if (phaseDone)
					nextPhase = lastBit ? i2cPkg::phaseMasterAckLow : i2cPkg::phaseReadLow;
			i2cPkg::phaseMasterAckLow:
			begin
				if (phaseDone)
				begin
					nextPhase = i2cPkg::phaseMasterAckHigh;
					consume.receive = moreRead;	// ack promised, request used
				end
			end
			i2cPkg::phaseMasterAckHigh:
				if (phaseDone)
					nextPhase = moreRead ? i2cPkg::phaseReadLow : i2cPkg::phaseStop;
			i2cPkg::phaseStop:
			begin
				consume.send = 1'b1;	// late requests die with the transaction
				consume.receive = 1'b1;
				if (phaseDone)
					nextPhase = i2cPkg::phaseIdle;
			end
			default: nextPhase = i2cPkg::phaseIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			phase <= i2cPkg::phaseIdle;
			bitIdx <= i2cPkg::msbIndex;
			readMode <= 1'b0;
			addrByte <= 1'b0;
			moreRead <= 1'b0;
			sended <= 1'b0;
		end
		else
		begin
			phase <= nextPhase;
			sended <= byteSent;	// high in the first ack low cycle
			if (phaseDone && ((phase == i2cPkg::phaseStart) ||
				(phase == i2cPkg::phaseRestartStart)))
			begin
				readMode <= dataSend[0];	// address lsb selects read
				addrByte <= 1'b1;
				bitIdx <= i2cPkg::msbIndex;
			end
			if (phaseDone && ((phase == i2cPkg::phaseBitHigh) ||
				(phase == i2cPkg::phaseReadHigh)))
				bitIdx <= lastBit ? i2cPkg::msbIndex : bitIdx - 1'b1;
			if (phaseDone && (phase == i2cPkg::phaseAckHigh))
				addrByte <= 1'b0;
			if (phaseDone && (phase == i2cPkg::phaseReadHigh) && lastBit)
				moreRead <= pending.receive;	// early guess for the ack level
			else if ((phase == i2cPkg::phaseMasterAckLow) && !phaseDone)
				moreRead <= pending.receive;	// settles before scl rises
		end
	end

	// sda level per phase
	always_comb
	begin
		case (phase)
			i2cPkg::phaseStart,
			i2cPkg::phaseRestartStart,
			i2cPkg::phaseStop: sdaRelease = 1'b0;	// start and stop edges
			i2cPkg::phaseBitLow,
			i2cPkg::phaseBitHigh: sdaRelease = dataSend[bitIdx];
			i2cPkg::phaseMasterAckLow,
			i2cPkg::phaseMasterAckHigh: sdaRelease = !moreRead;	// nack on last byte
			default: sdaRelease = 1'b1;	// idle, restart release, slave phases
		endcase
	end

endmodule

// ==== rtl/i2cCommandLatch.sv ====
`timescale 1ns/1ps

module i2cCommandLatch
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic send,
	input logic receive,
	input i2cPkg::pendingReq_t consume,
	output i2cPkg::pendingReq_t pending
);

	i2cPkg::pendingReq_t strobe;	// raw host requests in pending layout
	i2cPkg::pendingReq_t kept;	// requests that survive this cycle

	assign strobe = '{start: start, send: send, receive: receive};
	assign kept = pending & ~consume;	// consumed bits drop next cycle

	always_ff @(posedge clk)
	begin
		if (!reset)
			pending <= '0;	// nothing requested after reset
		else
			pending <= strobe | kept;	// a fresh strobe beats a clear
	end

endmodule

// ==== rtl/i2cMaster.sv ====
`timescale 1ns/1ps

module i2cMaster
#(
	parameter int quarterCycles = 62	// 100 kHz scl from a 25 MHz clk
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic send,
	input logic receive,
	input byte dataSend,
	output logic ready,
	output logic sended,
	output logic received,
	output byte dataReceive,
	inout wire sda,
	inout wire scl
);

	i2cPkg::pendingReq_t pending;
	i2cPkg::pendingReq_t consume;
	i2cPkg::busPhase_t phase;
	i2cPkg::sampleCmd_t sample;
	logic phaseDone;
	logic sclRelease;
	logic sdaRelease;
	logic ackSeen;
	logic sdaIn;	// wired-and level seen on the bus

	assign sda = sdaRelease ? 1'bz : 1'b0;	// open drain, pull-up gives the high
	assign scl = sclRelease ? 1'bz : 1'b0;
	assign sdaIn = sda;

	i2cCommandLatch commandLatch
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.send(send),
		.receive(receive),
		.consume(consume),
		.pending(pending)
	);

	i2cByteSequencer byteSequencer
	(
		.clk(clk),
		.reset(reset),
		.pending(pending),
		.dataSend(dataSend),
		.ackSeen(ackSeen),
		.phaseDone(phaseDone),
		.phase(phase),
		.consume(consume),
		.sample(sample),
		.sdaRelease(sdaRelease),
		.ready(ready),
		.sended(sended)
	);

	i2cBitTimer #(.quarterCycles(quarterCycles)) bitTimer
	(
		.clk(clk),
		.reset(reset),
		.phase(phase),
		.phaseDone(phaseDone),
		.sclRelease(sclRelease)
	);

	i2cReadCapture readCapture
	(
		.clk(clk),
		.reset(reset),
		.sdaIn(sdaIn),
		.sample(sample),
		.ackSeen(ackSeen),
		.dataReceive(dataReceive),
		.received(received)
	);

endmodule

// ==== rtl/i2cPkg.sv ====
package i2cPkg;

	localparam int byteBits = 8;	// bits per byte on the bus, fixed by i2c

	typedef logic [$clog2(byteBits)-1:0] bitIndex_t;	// position of a bit within a byte

	localparam bitIndex_t msbIndex = bitIndex_t'(byteBits - 1);	// bytes go msb first

	typedef enum logic [3:0]
	{
		phaseIdle,	// bus free, both lines released
		phaseStart,	// sda falls while scl is high
		phaseRestartRelease,	// scl low, then released with sda high
		phaseRestartStart,	// sda falls again while scl is high
		phaseBitLow,	// write bit setup
		phaseBitHigh,	// write bit valid
		phaseAckLow,	// master lets go of sda for the slave
		phaseAckHigh,	// slave ack is sampled here
		phaseReadLow,	// slave drives the next data bit
		phaseReadHigh,	// data bit is sampled here
		phaseMasterAckLow,	// master ack or nack setup
		phaseMasterAckHigh,	// master ack or nack valid
		phaseStop	// scl rises with sda low, sda released in idle
	} busPhase_t;

	typedef struct packed
	{
		logic start;	// open or restart a transaction
		logic send;	// one more write byte
		logic receive;	// one more read byte
	} pendingReq_t;

	typedef struct packed
	{
		logic sampleAck;	// sda is the slave acknowledge
		logic sampleData;	// sda is a data bit
		logic clearAck;	// an acknowledge phase follows
	} sampleCmd_t;

endpackage

// ==== rtl/i2cReadCapture.sv ====
`timescale 1ns/1ps

module i2cReadCapture
(
	input logic clk,
	input logic reset,
	input logic sdaIn,
	input i2cPkg::sampleCmd_t sample,
	output logic ackSeen,
	output byte dataReceive,
	output logic received
);

	logic [i2cPkg::byteBits-2:0] shiftReg;	// first seven bits of the byte
	i2cPkg::bitIndex_t bitCount;	// data bits taken so far
	logic ackFlag;	// slave pulled sda low in the last ack
	logic byteDone;

	assign byteDone = sample.sampleData && (bitCount == i2cPkg::msbIndex);
	assign ackSeen = sample.sampleAck ? !sdaIn : ackFlag;	// live during the sample cycle

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			bitCount <= '0;
			ackFlag <= 1'b0;
			received <= 1'b0;
		end
		else
		begin
			received <= byteDone;	// one cycle after the eighth sample
			if (sample.clearAck)
			begin
				ackFlag <= 1'b0;
				bitCount <= '0;	// realign before any read byte
			end
			else if (sample.sampleAck)
				ackFlag <= !sdaIn;
			if (sample.sampleData)
				bitCount <= bitCount + 1'b1;	// wraps after the eighth bit
		end
	end

	always_ff @(posedge clk)
	begin
		if (sample.sampleData)
			shiftReg <= {shiftReg[i2cPkg::byteBits-3:0], sdaIn};	// msb arrives first
		if (byteDone)
			dataReceive <= {shiftReg, sdaIn};	// held until the next byte completes
	end

endmodule
